/* rtl/cam_pkg.sv */
package cam_pkg;

   ////////////////////////////////////////
   // xvga 1024x768 @ 60Hz, 65 MHz pixel clock
   localparam int h_active = 1024;
   localparam int h_fp     = 24;
   localparam int h_sync   = 136;
   localparam int h_bp     = 160;
   localparam int h_total  = h_active + h_fp + h_sync + h_bp;   // 1344

   localparam int v_active = 768;
   localparam int v_fp     = 3;
   localparam int v_sync   = 6;
   localparam int v_bp     = 29;
   localparam int v_total  = v_active + v_fp + v_sync + v_bp;   // 806

   localparam int display_latency = 3;   // counter value to vga pins

   ////////////////////////////////////////
   // camera frame store
   localparam int fb_width  = 320;
   localparam int fb_height = 240;
   localparam int fb_depth  = fb_width * fb_height;   // 76800
   localparam int fb_addr_w = 17;
   localparam int pix_w     = 12;                     // rgb444

   localparam logic [3:0] chan_mid = 4'd8;   // threshold split point

   // processing modes
   localparam logic [2:0] mode_pass  = 3'd0;
   localparam logic [2:0] mode_diff  = 3'd1;
   localparam logic [2:0] mode_red   = 3'd2;
   localparam logic [2:0] mode_green = 3'd3;
   localparam logic [2:0] mode_blue  = 3'd4;

   ////////////////////////////////////////
   typedef struct packed {
      logic [10:0] hcount;
      logic [9:0]  vcount;
      logic        hsync;   // active low
      logic        vsync;   // active low
      logic        blank;
   } vga_timing_t;

   // counters at zero, syncs idle
   localparam vga_timing_t vga_idle = '{hcount: '0, vcount: '0, hsync: 1'b1,
                                        vsync: 1'b1, blank: 1'b0};

   typedef struct packed {
      logic       pclk;
      logic       vsync;
      logic       href;
      logic [7:0] data;
   } cam_pins_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb444_t;

   typedef struct packed {
      logic                 we;
      logic [fb_addr_w-1:0] addr;
      rgb444_t              pixel;
   } fb_write_t;

   // one camera word, seen as two bytes while assembling, rgb565 after
   typedef union packed {
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
      struct packed {
         logic [4:0] r;
         logic [5:0] g;
         logic [4:0] b;
      } rgb565;
   } cam_word_u;

endpackage

/* rtl/cam_sync.sv */
`timescale 1ns/1ps

module cam_sync import cam_pkg::*; (
   input  logic       clk_65mhz,
   input  logic       reset_in,
   input  logic [7:0] cam_data,   // raw camera byte
   input  logic [2:0] cam_ctl,    // pclk, vsync, href
   output cam_pins_t  pins,       // two flops behind the pins
   output logic       cam_xclk    // drive clock back to camera
);

   cam_pins_t  pins_meta;    // first stage, may go metastable
   logic [1:0] xclk_count;   // free running divide by 4

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         pins_meta  <= '0;
         pins       <= '0;
         xclk_count <= 2'b00;
      end else begin
         pins_meta.pclk  <= cam_ctl[0];
         pins_meta.vsync <= cam_ctl[1];
         pins_meta.href  <= cam_ctl[2];
         pins_meta.data  <= cam_data;
         pins            <= pins_meta;   // second stage
         xclk_count      <= xclk_count + 2'b01;
      end
   end

   // high for counts 2 and 3, so ~16 MHz at 50% duty
   assign cam_xclk = xclk_count[1];

endmodule

/* rtl/cam_capture.sv */
`timescale 1ns/1ps

module cam_capture import cam_pkg::*; (
   input  logic      clk_65mhz,
   input  logic      reset_in,
   input  cam_pins_t pins,
   output cam_word_u cam_word,      // assembled rgb565 word
   output logic      pixel_valid,   // one cycle, word complete
   output logic      frame_done     // one cycle, vsync rose
);

   logic pclk_prev;
   logic vsync_prev;
   logic byte_phase;   // 0 waits for hi byte, 1 waits for lo
   logic pclk_rise;

   // pclk is only a level here, edge found in the 65 MHz domain
   assign pclk_rise = pins.pclk & ~pclk_prev;

   ////////////////////////////////////////
   // edge detect and byte phase
   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         pclk_prev   <= 1'b0;
         vsync_prev  <= 1'b0;
         byte_phase  <= 1'b0;
         pixel_valid <= 1'b0;
         frame_done  <= 1'b0;
      end else begin
         pclk_prev   <= pins.pclk;
         vsync_prev  <= pins.vsync;
         frame_done  <= pins.vsync & ~vsync_prev;   // end of frame
         pixel_valid <= 1'b0;
         if (!pins.href) begin
            byte_phase <= 1'b0;   // line gap restarts the pair
         end else if (pclk_rise) begin
            byte_phase  <= ~byte_phase;
            pixel_valid <= byte_phase;   // lo byte just taken
         end
      end
   end

   ////////////////////////////////////////
   // byte capture, no reset on the word itself
   always_ff @(posedge clk_65mhz) begin
      if (pins.href && pclk_rise) begin
         if (!byte_phase) begin
            cam_word.bytes.hi <= pins.data;   // r5 g3
         end else begin
            cam_word.bytes.lo <= pins.data;   // g3 b5
         end
      end
   end

endmodule

/* rtl/capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl import cam_pkg::*; (
   input  logic                 clk_65mhz,
   input  logic                 reset_in,
   input  logic [3:0]           mode_sw,       // diff, red, green, blue
   input  logic                 pixel_valid,
   input  logic                 frame_done,
   output logic [2:0]           proc_mode,     // held for a whole frame
   output logic                 wr_en,         // lines up with the pixel
   output logic [fb_addr_w-1:0] wr_addr
);

   logic [2:0]           mode_dec;
   logic [fb_addr_w-1:0] addr_cnt;        // next free slot
   logic                 addr_in_range;

   // lowest switch wins
   always_comb begin
      if (mode_sw[0]) begin
         mode_dec = mode_diff;
      end else if (mode_sw[1]) begin
         mode_dec = mode_red;
      end else if (mode_sw[2]) begin
         mode_dec = mode_green;
      end else if (mode_sw[3]) begin
         mode_dec = mode_blue;
      end else begin
         mode_dec = mode_pass;
      end
   end

   assign addr_in_range = addr_cnt < fb_addr_w'(fb_depth);   // past 320x240 is dropped

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         proc_mode <= mode_pass;
         addr_cnt  <= '0;
         wr_en     <= 1'b0;
      end else begin
         if (frame_done) begin
            proc_mode <= mode_dec;   // switch only between frames
         end
         if (frame_done) begin
            addr_cnt <= '0;
         end else if (pixel_valid && addr_in_range) begin
            addr_cnt <= addr_cnt + 1'b1;   // stops at fb_depth
         end
         wr_en <= pixel_valid & addr_in_range;
      end
   end

   // address from the valid cycle, one stage late like the pixel
   always_ff @(posedge clk_65mhz) begin
      wr_addr <= addr_cnt;
   end

endmodule

/* rtl/pixel_process.sv */
`timescale 1ns/1ps

module pixel_process import cam_pkg::*; (
   input  logic       clk_65mhz,
   input  logic       reset_in,
   input  logic [2:0] proc_mode,
   input  cam_word_u  cam_word,
   input  logic       pixel_valid,
   input  logic       frame_done,
   output rgb444_t    pixel         // one cycle after pixel_valid
);

   cam_word_u  prev_word;              // last valid word this frame
   logic [3:0] cur_r, cur_g, cur_b;
   logic [3:0] prv_r, prv_g, prv_b;
   logic       r_above, g_above, b_above;
   logic       r_below, g_below, b_below;
   rgb444_t    next_pixel;

   function automatic logic [3:0] abs_diff(input logic [3:0] a, input logic [3:0] b);
      return (a > b) ? a - b : b - a;
   endfunction

   // top four bits of each rgb565 field
   assign cur_r = cam_word.rgb565.r[4:1];
   assign cur_g = cam_word.rgb565.g[5:2];
   assign cur_b = cam_word.rgb565.b[4:1];
   assign prv_r = prev_word.rgb565.r[4:1];
   assign prv_g = prev_word.rgb565.g[5:2];
   assign prv_b = prev_word.rgb565.b[4:1];

   assign r_above = cur_r > chan_mid;
   assign g_above = cur_g > chan_mid;
   assign b_above = cur_b > chan_mid;
   assign r_below = cur_r < chan_mid;   // exactly mid counts as neither
   assign g_below = cur_g < chan_mid;
   assign b_below = cur_b < chan_mid;

   always_comb begin
      case (proc_mode)
         mode_diff:  next_pixel = '{r: abs_diff(cur_r, prv_r), g: abs_diff(cur_g, prv_g),
                                    b: abs_diff(cur_b, prv_b)};
         mode_red:   next_pixel = (r_above && g_below && b_below) ? 12'hF00 : 12'h000;
         mode_green: next_pixel = (g_above && r_below && b_below) ? 12'h0F0 : 12'h000;
         mode_blue:  next_pixel = (b_above && r_below && g_below) ? 12'h00F : 12'h000;
         default:    next_pixel = '{r: cur_r, g: cur_g, b: cur_b};   // pass
      endcase
   end

   always_ff @(posedge clk_65mhz) begin
      if (reset_in || frame_done) begin
         prev_word <= '0;   // first pixel of a frame diffs against black
      end else if (pixel_valid) begin
         prev_word <= cam_word;
      end
   end

   always_ff @(posedge clk_65mhz) begin
      if (pixel_valid) begin
         pixel <= next_pixel;
      end
   end

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer import cam_pkg::*; (
   input  logic                 clk_65mhz,
   input  fb_write_t            wr,        // capture side
   input  logic [fb_addr_w-1:0] rd_addr,   // display side
   output rgb444_t              rd_pixel   // one cycle after rd_addr
);

   // 320x240 of rgb444, maps onto block ram
   logic [pix_w-1:0] mem [fb_depth];

   always_ff @(posedge clk_65mhz) begin
      if (wr.we) begin
         mem[wr.addr] <= wr.pixel;
      end
      rd_pixel <= rgb444_t'(mem[rd_addr]);   // registered read port
   end

endmodule

/* rtl/xvga_timing.sv */
`timescale 1ns/1ps

module xvga_timing import cam_pkg::*; (
   input  logic        clk_65mhz,
   input  logic        reset_in,
   output vga_timing_t timing      // counters, syncs, blank all registered
);

   logic hblank, vblank;
   logic hblank_on, hsync_on, hsync_off, h_reset;
   logic vblank_on, vsync_on, vsync_off, v_reset;
   logic next_hblank, next_vblank;

   ////////////////////////////////////////
   // horizontal compare points one early so the regs land on time
   assign hblank_on = timing.hcount == 11'(h_active - 1);                   // 1023
   assign hsync_on  = timing.hcount == 11'(h_active + h_fp - 1);            // 1047
   assign hsync_off = timing.hcount == 11'(h_active + h_fp + h_sync - 1);   // 1183
   assign h_reset   = timing.hcount == 11'(h_total - 1);                    // 1343

   // vertical ones only move at end of line
   assign vblank_on = h_reset && (timing.vcount == 10'(v_active - 1));
   assign vsync_on  = h_reset && (timing.vcount == 10'(v_active + v_fp - 1));
   assign vsync_off = h_reset && (timing.vcount == 10'(v_active + v_fp + v_sync - 1));
   assign v_reset   = h_reset && (timing.vcount == 10'(v_total - 1));

   assign next_hblank = h_reset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = v_reset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         timing <= vga_idle;   // syncs idle high
         hblank <= 1'b0;
         vblank <= 1'b0;
      end else begin
         timing.hcount <= h_reset ? '0 : timing.hcount + 11'd1;
         if (h_reset) begin
            timing.vcount <= v_reset ? '0 : timing.vcount + 10'd1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;

         // active low pulse starts at h 1048
         if (hsync_on) begin
            timing.hsync <= 1'b0;
         end else if (hsync_off) begin
            timing.hsync <= 1'b1;
         end
         if (vsync_on) begin
            timing.vsync <= 1'b0;
         end else if (vsync_off) begin
            timing.vsync <= 1'b1;
         end

         // lands with the counter value it belongs to
         timing.blank <= next_vblank | next_hblank;
      end
   end

endmodule

/* rtl/display_mux.sv */
`timescale 1ns/1ps

module display_mux import cam_pkg::*; (
   input  logic                 clk_65mhz,
   input  logic                 reset_in,
   input  logic [1:0]           disp_mode,   // 01 outline, 10 bars, else camera
   input  logic                 zoom,        // 2x camera into 640x480
   input  vga_timing_t          timing,
   input  rgb444_t              rd_pixel,
   output logic [fb_addr_w-1:0] rd_addr,
   output logic [3:0]           vga_r,
   output logic [3:0]           vga_g,
   output logic [3:0]           vga_b,
   output logic                 vga_hs,      // active high at the pins
   output logic                 vga_vs
);

   logic [fb_addr_w-1:0] h_term, v_term;
   logic                 in_window;
   vga_timing_t          timing_d1, timing_d2;   // follow the ram
   logic                 win_d1, win_d2;
   logic                 border;
   rgb444_t              pix_sel;

   ////////////////////////////////////////
   // stage 0, address and window
   always_comb begin
      if (zoom) begin
         h_term    = fb_addr_w'(timing.hcount[10:1]);   // h/2
         v_term    = fb_addr_w'(timing.vcount[9:1]);    // v/2
         in_window = (timing.hcount < 11'(2 * fb_width)) &&
                     (timing.vcount < 10'(2 * fb_height));
      end else begin
         h_term    = fb_addr_w'(timing.hcount);
         v_term    = fb_addr_w'(timing.vcount);
         in_window = (timing.hcount < 11'(fb_width)) && (timing.vcount < 10'(fb_height));
      end
   end

   // kept in range outside the window
   always_ff @(posedge clk_65mhz) begin
      rd_addr <= in_window ? h_term + v_term * fb_addr_w'(fb_width) : '0;
   end

   ////////////////////////////////////////
   // picture select on the twice delayed counters
   assign border = (timing_d2.hcount == 11'd0) || (timing_d2.hcount == 11'(h_active - 1)) ||
                   (timing_d2.hcount == 11'(h_active / 2)) || (timing_d2.vcount == 10'd0) ||
                   (timing_d2.vcount == 10'(v_active - 1)) ||
                   (timing_d2.vcount == 10'(v_active / 2));

   always_comb begin
      case (disp_mode)
         2'b01:   pix_sel = rgb444_t'({12{border}});   // white outline
         2'b10:   pix_sel = rgb444_t'({{4{timing_d2.hcount[8]}}, {4{timing_d2.hcount[7]}},
                                       {4{timing_d2.hcount[6]}}});
         default: pix_sel = win_d2 ? rd_pixel : rgb444_t'(12'hFFF);   // white outside
      endcase
   end

   always_ff @(posedge clk_65mhz) begin
      if (reset_in) begin
         timing_d1 <= vga_idle;
         timing_d2 <= vga_idle;
         win_d1    <= 1'b0;
         win_d2    <= 1'b0;
         vga_r     <= 4'h0;
         vga_g     <= 4'h0;
         vga_b     <= 4'h0;
         vga_hs    <= 1'b0;
         vga_vs    <= 1'b0;
      end else begin
         timing_d1 <= timing;      // address cycle
         win_d1    <= in_window;
         timing_d2 <= timing_d1;   // ram cycle
         win_d2    <= win_d1;
         vga_r     <= timing_d2.blank ? 4'h0 : pix_sel.r;
         vga_g     <= timing_d2.blank ? 4'h0 : pix_sel.g;
         vga_b     <= timing_d2.blank ? 4'h0 : pix_sel.b;
         vga_hs    <= ~timing_d2.hsync;   // flip polarity for the board
         vga_vs    <= ~timing_d2.vsync;
      end
   end

endmodule

/* rtl/cam_top.sv */
`timescale 1ns/1ps

module cam_top import cam_pkg::*; (
   input  logic       clk_65mhz,
   input  logic       reset_in,
   input  logic [7:0] cam_data,
   input  logic [2:0] cam_ctl,    // pclk, vsync, href
   input  logic [6:0] ctrl_sw,    // [1:0] display, [2] zoom, [6:3] processing
   output logic       cam_xclk,
   output logic [3:0] vga_r,
   output logic [3:0] vga_g,
   output logic [3:0] vga_b,
   output logic       vga_hs,
   output logic       vga_vs
);

   cam_pins_t            pins;
   cam_word_u            cam_word;
   logic                 pixel_valid;
   logic                 frame_done;
   logic [2:0]           proc_mode;
   logic                 wr_en;
   logic [fb_addr_w-1:0] wr_addr;
   rgb444_t              pixel;
   fb_write_t            fb_wr;
   logic [fb_addr_w-1:0] rd_addr;
   rgb444_t              rd_pixel;
   vga_timing_t          timing;

   ////////////////////////////////////////
   // camera side
   cam_sync u_cam_sync (
      .clk_65mhz (clk_65mhz), .reset_in (reset_in), .cam_data (cam_data),
      .cam_ctl   (cam_ctl),   .pins     (pins),     .cam_xclk (cam_xclk)
   );

   cam_capture u_cam_capture (
      .clk_65mhz   (clk_65mhz),   .reset_in   (reset_in), .pins (pins),
      .cam_word    (cam_word),    .pixel_valid (pixel_valid),
      .frame_done  (frame_done)
   );

   capture_ctrl u_capture_ctrl (
      .clk_65mhz   (clk_65mhz),   .reset_in   (reset_in),   .mode_sw (ctrl_sw[6:3]),
      .pixel_valid (pixel_valid), .frame_done (frame_done), .proc_mode (proc_mode),
      .wr_en       (wr_en),       .wr_addr    (wr_addr)
   );

   pixel_process u_pixel_process (
      .clk_65mhz   (clk_65mhz),   .reset_in (reset_in), .proc_mode  (proc_mode),
      .cam_word    (cam_word),    .pixel_valid (pixel_valid),
      .frame_done  (frame_done),  .pixel    (pixel)
   );

   assign fb_wr = '{we: wr_en, addr: wr_addr, pixel: pixel};

   frame_buffer u_frame_buffer (
      .clk_65mhz (clk_65mhz), .wr (fb_wr), .rd_addr (rd_addr), .rd_pixel (rd_pixel)
   );

   ////////////////////////////////////////
   // display side
   xvga_timing u_xvga_timing (
      .clk_65mhz (clk_65mhz), .reset_in (reset_in), .timing (timing)
   );

   display_mux u_display_mux (
      .clk_65mhz (clk_65mhz), .reset_in (reset_in), .disp_mode (ctrl_sw[1:0]),
      .zoom      (ctrl_sw[2]), .timing  (timing),   .rd_pixel  (rd_pixel),
      .rd_addr   (rd_addr),   .vga_r    (vga_r),    .vga_g     (vga_g),
      .vga_b     (vga_b),     .vga_hs   (vga_hs),   .vga_vs    (vga_vs)
   );

endmodule

/* sim/tb_cam_top.sv */
`timescale 1ns/1ps

module tb_cam_top import cam_pkg::*; ();

   localparam int num_records     = 6;
   localparam int rec_len         = 18;                // sw, count, 8 words, 8 pixels
   localparam int clk_period      = 40;
   localparam int last_check_line = 2 * fb_height + 2;   // just past the zoomed window
   localparam longint watchdog_ns = longint'(num_records + 3) * h_total * v_total * clk_period;

   logic       clk_65mhz = 1'b0;
   logic       reset_in;
   logic [7:0] cam_data;
   logic       cam_pclk, cam_vsync, cam_href;
   logic [6:0] ctrl_sw;                 // [1:0] display, [2] zoom, [6:3] processing
   logic       cam_xclk;
   logic [3:0] vga_r, vga_g, vga_b;
   logic       vga_hs, vga_vs;

   logic [15:0] patterns [num_records * rec_len];
   logic [11:0] exp_pix [8];            // stored pixels of the current record
   int          exp_count;
   integer      seed = 96699;
   int          errors, checks, cam_hits;
   logic        check_on;               // colour compare enabled
   logic        hs_seen;
   logic        rst_q;                  // reset as the DUT saw it

   ////////////////////////////////////////
   // display model counters run alongside the DUT
   logic [10:0] h_cnt;
   logic [9:0]  v_cnt;
   logic [10:0] h_pipe [display_latency];
   logic [9:0]  v_pipe [display_latency];
   logic [10:0] dh;                     // counter value now at the pins
   logic [9:0]  dv;
   logic [13:0] view;                   // camera flag, known flag, colour
   logic        exp_hs, exp_vs;
   logic [1:0]  xclk_div;               // divide by 4 for the camera clock

   cam_top u_cam_top (
      .clk_65mhz (clk_65mhz), .reset_in (reset_in), .cam_data (cam_data),
      .cam_ctl   ({cam_href, cam_vsync, cam_pclk}), .ctrl_sw (ctrl_sw),
      .cam_xclk  (cam_xclk),  .vga_r    (vga_r),    .vga_g    (vga_g),
      .vga_b     (vga_b),     .vga_hs   (vga_hs),   .vga_vs   (vga_vs)
   );

   always #(clk_period / 2) clk_65mhz = ~clk_65mhz;

   assign dh = h_pipe[display_latency - 1];
   assign dv = v_pipe[display_latency - 1];

   always @(posedge clk_65mhz) begin
      rst_q <= reset_in;
      if (reset_in) begin
         h_cnt    <= '0;
         v_cnt    <= '0;
         xclk_div <= 2'b00;
         for (int i = 0; i < display_latency; i++) begin
            h_pipe[i] <= '0;
            v_pipe[i] <= '0;
         end
      end else begin
         xclk_div <= xclk_div + 2'b01;
         if (h_cnt == 11'(h_total - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 10'(v_total - 1)) ? '0 : v_cnt + 10'd1;
         end else begin
            h_cnt <= h_cnt + 11'd1;
         end
         h_pipe[0] <= h_cnt;
         v_pipe[0] <= v_cnt;
         for (int i = 1; i < display_latency; i++) begin
            h_pipe[i] <= h_pipe[i - 1];   // shift toward the pins
            v_pipe[i] <= v_pipe[i - 1];
         end
      end
   end

   // picture expected at one screen position
   function automatic logic [13:0] expected_view(input logic [10:0] h, input logic [9:0] v,
                                                 input logic [2:0] sw);
      logic [11:0] pix;
      logic        cam;
      logic        known;
      logic        border;
      int          win_w, win_h, k, lines;
      cam    = 1'b0;
      known  = 1'b1;
      pix    = 12'h000;
      border = (h == 0) || (h == h_active - 1) || (h == h_active / 2) ||
               (v == 0) || (v == v_active - 1) || (v == v_active / 2);
      win_w  = sw[2] ? 2 * fb_width : fb_width;
      win_h  = sw[2] ? 2 * fb_height : fb_height;
      k      = sw[2] ? h / 2 : h;    // stored pixel index on the top line(s)
      lines  = sw[2] ? 2 : 1;
      if (h >= h_active || v >= v_active) begin
         pix = 12'h000;              // blanking
      end else if (sw[1:0] == 2'b01) begin
         pix = border ? 12'hFFF : 12'h000;
      end else if (sw[1:0] == 2'b10) begin
         pix = {{4{h[8]}}, {4{h[7]}}, {4{h[6]}}};
      end else if (h >= win_w || v >= win_h) begin
         pix = 12'hFFF;              // white around the camera
      end else if (v < lines && k < exp_count) begin
         cam = 1'b1;
         pix = exp_pix[k];
      end else begin
         known = 1'b0;               // old frame buffer contents
      end
      return {cam, known, pix};
   endfunction

   ////////////////////////////////////////
   // pin checks on the falling edge
   always @(negedge clk_65mhz) begin
      if (rst_q) begin
         if ({vga_r, vga_g, vga_b, vga_hs, vga_vs} !== 14'd0) begin
            errors++;
            $display("Fail %0t ns: outputs not low during reset", $time);
         end
      end else begin
         exp_hs = (dh >= h_active + h_fp) && (dh < h_active + h_fp + h_sync);
         exp_vs = (dv >= v_active + v_fp) && (dv < v_active + v_fp + v_sync);
         view   = expected_view(dh, dv, ctrl_sw[2:0]);
         checks++;
         if (cam_xclk !== xclk_div[1]) begin
            errors++;
            $display("Fail %0t ns: cam_xclk %b, expected %b", $time, cam_xclk, xclk_div[1]);
         end
         if (vga_hs !== exp_hs || vga_vs !== exp_vs) begin
            errors++;
            $display("Fail %0t ns: syncs %b%b, expected %b%b at h %0d v %0d",
                     $time, vga_hs, vga_vs, exp_hs, exp_vs, dh, dv);
         end
         if (!hs_seen && vga_hs === 1'b1) begin
            hs_seen = 1'b1;
            if (h_cnt != 11'(h_active + h_fp + display_latency)) begin
               errors++;
               $display("Fail %0t ns: first hsync at hcount %0d", $time, h_cnt);
            end
         end
         if (check_on && view[12]) begin
            if (view[13]) begin
               cam_hits++;
            end
            if ({vga_r, vga_g, vga_b} !== view[11:0]) begin
               errors++;
               $display("Fail %0t ns: colour %h, expected %h at h %0d v %0d",
                        $time, {vga_r, vga_g, vga_b}, view[11:0], dh, dv);
            end
         end
      end
   end

   ////////////////////////////////////////
   // camera driver
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_65mhz);
      #2;
   endtask

   task automatic send_byte(input logic [7:0] value, input logic href);
      cam_data = value;
      cam_href = href;
      cam_pclk = 1'b0;   // data settles in the low half
      wait_cycles(2);
      cam_pclk = 1'b1;   // taken on this edge
      wait_cycles(2);
   endtask

   task automatic send_filler(input int n);
      repeat (n) begin
         send_byte(8'($random(seed)), 1'b0);
      end
   endtask

   task automatic pulse_vsync();
      cam_vsync = 1'b1;
      wait_cycles(4);
      cam_vsync = 1'b0;
      wait_cycles(4);
   endtask

   // display position waits end in the drive slot
   task automatic wait_line(input int line);
      do begin
         @(negedge clk_65mhz);
      end while (!(dh == 0 && dv == line));
      wait_cycles(1);
   endtask

   task automatic wait_frame_end();
      do begin
         @(negedge clk_65mhz);
      end while (!(dh == h_total - 2 && dv == v_total - 1));
      wait_cycles(1);
   endtask

   // one camera frame from a pattern record
   task automatic write_record(input int r);
      int base;
      base      = r * rec_len;
      ctrl_sw   = patterns[base][6:0];
      exp_count = patterns[base + 1];
      for (int i = 0; i < 8; i++) begin
         exp_pix[i] = patterns[base + 10 + i][11:0];
      end
      pulse_vsync();   // mode latches, address clears
      send_filler(4);
      for (int i = 0; i < exp_count; i++) begin
         send_byte(patterns[base + 2 + i][15:8], 1'b1);
         send_byte(patterns[base + 2 + i][7:0], 1'b1);
      end
      send_filler(4);
      pulse_vsync();
   endtask

   initial begin
      reset_in  = 1'b1;
      cam_data  = 8'h00;
      cam_pclk  = 1'b0;
      cam_vsync = 1'b0;
      cam_href  = 1'b0;
      ctrl_sw   = 7'b0000001;   // outline first
      errors    = 0;
      checks    = 0;
      cam_hits  = 0;
      exp_count = 0;
      check_on  = 1'b1;
      hs_seen   = 1'b0;
      $readmemh("sim/cam_patterns.txt", patterns);
      if (^patterns[0] === 1'bx) begin
         errors++;
         $display("pattern file sim/cam_patterns.txt could not be read");
      end
      wait_cycles(2);
      reset_in = 1'b0;

      wait_frame_end();
      ctrl_sw = 7'b0000010;   // colour bars
      wait_line(last_check_line);
      check_on = 1'b0;

      for (int r = 0; r < num_records; r++) begin
         write_record(r);
         wait_frame_end();
         cam_hits = 0;
         check_on = 1'b1;
         wait_line(last_check_line);
         check_on = 1'b0;
         if (cam_hits != exp_count * (ctrl_sw[2] ? 4 : 1)) begin
            errors++;
            $display("record %0d: only %0d camera pixels were compared", r, cam_hits);
         end
      end
      if (!hs_seen) begin
         errors++;
         $display("no hsync pulse was seen at the pins");
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(watchdog_ns);
      $display("timeout: run did not finish within %0d frame times", num_records + 3);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* sim/cam_patterns.txt */
// ctrl_sw count, camera words w0..w7 (rgb565), then stored pixels p0..p7 (rgb444)
// all hex, unused slots are zero
// pass, 1x
00 8 F800 07E0 001F FFFF 0000 8410 1234 A5C3 F00 0F0 00F FFF 000 888 14A AB1
// difference from previous pixel
08 6 F000 328E 328E 8782 001E A514 0000 0000 F00 C57 000 5A6 8FE AA5 000 000
// red threshold
10 6 F000 938E 8000 F400 C192 A084 0000 0000 F00 F00 000 000 000 F00 000 000
// green and blue switches, green wins
60 5 0780 748E 740E F79E 160C 0000 0000 0000 0F0 0F0 000 000 0F0 000 000 000
// blue threshold
40 4 001E 2192 2190 901E 0000 0000 0000 0000 00F 00F 000 000 000 000 000 000
// pass, zoom 2x
04 8 F000 0780 001E FFFF 8410 1234 A5C3 0000 F00 0F0 00F FFF 888 14A AB1 000

/* vlog.f */
rtl/cam_pkg.sv
rtl/cam_sync.sv
rtl/cam_capture.sv
rtl/capture_ctrl.sv
rtl/pixel_process.sv
rtl/frame_buffer.sv
rtl/xvga_timing.sv
rtl/display_mux.sv
rtl/cam_top.sv
sim/tb_cam_top.sv

/* Bender.yml */
package:
  name: cam_top

sources:
  - rtl/cam_pkg.sv
  - rtl/cam_sync.sv
  - rtl/cam_capture.sv
  - rtl/capture_ctrl.sv
  - rtl/pixel_process.sv
  - rtl/frame_buffer.sv
  - rtl/xvga_timing.sv
  - rtl/display_mux.sv
  - rtl/cam_top.sv
  - target: test
    files:
      - sim/tb_cam_top.sv
